// File: list.f
logic/arp_pkg.sv
logic/arp_if.sv
logic/arp_frame_decode.sv
logic/arp_cache.sv
logic/arp_resolver.sv
logic/arp_tx_frame.sv
logic/arp_top.sv
verif/arp_assertions.sv
verif/arp_tb.sv

// File: logic/arp_cache.sv
`timescale 1ns/1ps

module arp_cache import arp_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           clear_cache,
    arp_cache_if.responder port
);

    typedef logic [$clog2(CACHE_ENTRIES)-1:0] entry_idx_t;

    logic       entry_valid [CACHE_ENTRIES];
    ip_addr_t   entry_ip    [CACHE_ENTRIES];
    mac_addr_t  entry_mac   [CACHE_ENTRIES];
    entry_idx_t rr_ptr;
    entry_idx_t write_idx;
    logic       write_hit;
    logic       query_hit;
    mac_addr_t  query_mac;

    // parallel compare of every entry against both addresses
    always_comb begin
        write_hit = 1'b0;
        write_idx = rr_ptr;
        query_hit = 1'b0;
        query_mac = '0;
        for (int i = 0; i < CACHE_ENTRIES; i++) begin
            if (entry_valid[i] && (entry_ip[i] == port.write_ip)) begin
                write_hit = 1'b1;
                write_idx = entry_idx_t'(i);
            end
            if (entry_valid[i] && (entry_ip[i] == port.query_ip)) begin
                query_hit = 1'b1;
                query_mac = entry_mac[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            for (int i = 0; i < CACHE_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
            rr_ptr <= '0;
        end else if (port.write_valid) begin
            entry_valid[write_idx] <= 1'b1;
            // only a new binding advances the victim pointer
            if (!write_hit) begin
                if (rr_ptr == entry_idx_t'(CACHE_ENTRIES - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= rr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port.write_valid) begin
            entry_ip[write_idx]  <= port.write_ip;
            entry_mac[write_idx] <= port.write_mac;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port.resp_valid <= 1'b0;
        end else begin
            port.resp_valid <= port.query_valid;
        end
    end

    always_ff @(posedge clk) begin
        port.resp_error <= !query_hit;
        port.resp_mac   <= query_mac;
    end

endmodule

// File: logic/arp_frame_decode.sv
`timescale 1ns/1ps

module arp_frame_decode import arp_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         rx_valid,
    output logic         rx_ready,
    input  mac_addr_t    rx_src_mac,
    input  arp_oper_t    rx_oper,
    input  mac_addr_t    rx_sha,
    input  ip_addr_t     rx_spa,
    input  mac_addr_t    rx_tha,
    input  ip_addr_t     rx_tpa,
    input  mac_addr_t    local_mac,
    input  ip_addr_t     local_ip,
    arp_tx_req_if.source reply,
    arp_cache_if.writer  cache
);

    logic accept;
    logic arp_match;
    logic inarp_match;

    // frames stall whenever a reply could not be taken
    assign rx_ready = reply.ready;
    assign accept   = rx_valid && rx_ready;

    // target matching for the two request kinds we answer
    assign arp_match   = (rx_oper == ARP_OPER_REQUEST) && (rx_tpa == local_ip);
    assign inarp_match = (rx_oper == ARP_OPER_INARP_REQUEST) && (rx_tha == local_mac);

    assign reply.valid    = accept && (arp_match || inarp_match);
    assign reply.dest_mac = rx_src_mac;
    assign reply.tha      = rx_sha;
    assign reply.tpa      = rx_spa;

    always_comb begin
        if (inarp_match) begin
            reply.oper = ARP_OPER_INARP_REPLY;
        end else begin
            reply.oper = ARP_OPER_REPLY;
        end
    end

    // every accepted frame teaches us the sender binding
    always_ff @(posedge clk) begin
        if (rst) begin
            cache.write_valid <= 1'b0;
        end else begin
            cache.write_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cache.write_ip  <= rx_spa;
            cache.write_mac <= rx_sha;
        end
    end

endmodule

// File: logic/arp_if.sv
`timescale 1ns/1ps

// one outgoing frame request, valid is a single-cycle strobe
interface arp_tx_req_if import arp_pkg::*; ();

    logic      valid;
    logic      ready;
    mac_addr_t dest_mac;
    arp_oper_t oper;
    mac_addr_t tha;
    ip_addr_t  tpa;

    modport source (output valid, dest_mac, oper, tha, tpa, input ready);
    modport sink   (input valid, dest_mac, oper, tha, tpa, output ready);

endinterface

// query side is a level, answered one cycle later
interface arp_cache_if import arp_pkg::*; ();

    logic      query_valid;
    ip_addr_t  query_ip;
    logic      resp_valid;
    logic      resp_error;
    mac_addr_t resp_mac;
    logic      write_valid;
    ip_addr_t  write_ip;
    mac_addr_t write_mac;

    modport requester (output query_valid, query_ip, input resp_valid, resp_error, resp_mac);
    // the cache answers queries and also takes the writes
    modport responder (input query_valid, query_ip, write_valid, write_ip, write_mac,
                       output resp_valid, resp_error, resp_mac);
    modport writer    (output write_valid, write_ip, write_mac);

endinterface

// File: logic/arp_pkg.sv
package arp_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // opcode values as they appear on the wire
    typedef enum logic [15:0] {
        ARP_OPER_REQUEST       = 16'h0001,
        ARP_OPER_REPLY         = 16'h0002,
        ARP_OPER_INARP_REQUEST = 16'h0008,
        ARP_OPER_INARP_REPLY   = 16'h0009
    } arp_oper_t;

    typedef enum logic [1:0] {
        RESOLVE_IDLE,
        RESOLVE_QUERY,
        RESOLVE_WAIT_REPLY,
        RESOLVE_RESPOND
    } resolve_state_t;

    localparam mac_addr_t MAC_BROADCAST = '1;
    localparam ip_addr_t  IP_BROADCAST  = '1;

    localparam int CACHE_ENTRIES = 8;

    // retry timing, counted in clock cycles
    localparam int REQUEST_RETRY_COUNT    = 4;
    localparam int RETRY_INTERVAL_CYCLES  = 64;
    localparam int REQUEST_TIMEOUT_CYCLES = 256;

    // wide enough for the longer of the two waits
    typedef logic [$clog2(REQUEST_TIMEOUT_CYCLES + 1)-1:0] timer_t;

endpackage

// File: logic/arp_resolver.sv
`timescale 1ns/1ps

module arp_resolver import arp_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           req_valid,
    output logic           req_ready,
    input  ip_addr_t       req_ip,
    output logic           resp_valid,
    input  logic           resp_ready,
    output logic           resp_error,
    output mac_addr_t      resp_mac,
    input  ip_addr_t       gateway_ip,
    input  ip_addr_t       subnet_mask,
    arp_cache_if.requester cache,
    arp_tx_req_if.source   request
);

    typedef logic [$clog2(REQUEST_RETRY_COUNT + 1)-1:0] retry_t;

    resolve_state_t state;
    resolve_state_t state_next;
    ip_addr_t       lookup_ip;
    retry_t         retry_cnt;
    timer_t         timer;
    logic           frame_pending;
    logic           in_subnet;
    logic           is_broadcast;
    logic           cache_hit;
    logic           cache_miss;
    logic           send_due;

    // request ip shares the gateway prefix
    assign in_subnet    = ((req_ip ^ gateway_ip) & subnet_mask) == '0;
    // limited broadcast, or every host bit set inside our subnet
    assign is_broadcast = (req_ip == IP_BROADCAST) ||
                          (in_subnet && (~(req_ip | subnet_mask) == '0));

    assign cache_hit  = cache.resp_valid && !cache.resp_error;
    assign cache_miss = cache.resp_valid && cache.resp_error;

    assign cache.query_valid = (state == RESOLVE_QUERY) || (state == RESOLVE_WAIT_REPLY);
    assign cache.query_ip    = lookup_ip;

    assign resp_valid = (state == RESOLVE_RESPOND);

    // first miss, a frame held back by a busy tx register, or retry timer expiry
    always_comb begin
        send_due = 1'b0;
        if (state == RESOLVE_QUERY) begin
            send_due = cache_miss;
        end else if ((state == RESOLVE_WAIT_REPLY) && !cache_hit) begin
            send_due = frame_pending || ((timer == '0) && (retry_cnt != '0));
        end
    end

    assign request.valid    = send_due && request.ready;
    assign request.dest_mac = MAC_BROADCAST;
    assign request.oper     = ARP_OPER_REQUEST;
    assign request.tha      = '0;
    assign request.tpa      = lookup_ip;

    always_comb begin
        state_next = state;
        case (state)
            RESOLVE_IDLE: begin
                if (req_valid && req_ready) begin
                    state_next = is_broadcast ? RESOLVE_RESPOND : RESOLVE_QUERY;
                end
            end
            RESOLVE_QUERY: begin
                if (cache_hit) begin
                    state_next = RESOLVE_RESPOND;
                end else if (cache_miss) begin
                    state_next = RESOLVE_WAIT_REPLY;
                end
            end
            RESOLVE_WAIT_REPLY: begin
                // learned in time, or out of frames and the timeout ran down
                if (cache_hit || ((timer == '0) && (retry_cnt == '0) && !frame_pending)) begin
                    state_next = RESOLVE_RESPOND;
                end
            end
            RESOLVE_RESPOND: begin
                if (resp_ready) begin
                    state_next = RESOLVE_IDLE;
                end
            end
            default: state_next = RESOLVE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= RESOLVE_IDLE;
            req_ready     <= 1'b0;
            frame_pending <= 1'b0;
            retry_cnt     <= '0;
            timer         <= '0;
        end else begin
            state         <= state_next;
            req_ready     <= (state_next == RESOLVE_IDLE);
            frame_pending <= send_due && !request.ready;
            if (state == RESOLVE_IDLE) begin
                retry_cnt <= retry_t'(REQUEST_RETRY_COUNT);
            end
            if (request.valid) begin
                retry_cnt <= retry_cnt - 1'b1;
                // last frame starts the final timeout
                if (retry_cnt > retry_t'(1)) begin
                    timer <= timer_t'(RETRY_INTERVAL_CYCLES - 1);
                end else begin
                    timer <= timer_t'(REQUEST_TIMEOUT_CYCLES - 1);
                end
            end else if ((state == RESOLVE_WAIT_REPLY) && (timer != '0)) begin
                timer <= timer - 1'b1;
            end
        end
    end

    // response fields track the cache until the machine leaves for respond
    always_ff @(posedge clk) begin
        case (state)
            RESOLVE_IDLE: begin
                lookup_ip  <= in_subnet ? req_ip : gateway_ip;
                resp_error <= 1'b0;
                resp_mac   <= MAC_BROADCAST;
            end
            RESOLVE_QUERY, RESOLVE_WAIT_REPLY: begin
                resp_error <= !cache_hit;
                resp_mac   <= cache_hit ? cache.resp_mac : '0;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/arp_top.sv
`timescale 1ns/1ps

module arp_top import arp_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // parsed incoming frames
    input  logic      rx_valid,
    output logic      rx_ready,
    input  mac_addr_t rx_src_mac,
    input  arp_oper_t rx_oper,
    input  mac_addr_t rx_sha,
    input  ip_addr_t  rx_spa,
    input  mac_addr_t rx_tha,
    input  ip_addr_t  rx_tpa,
    // outgoing frame fields
    output logic      tx_valid,
    input  logic      tx_ready,
    output mac_addr_t tx_dest_mac,
    output arp_oper_t tx_oper,
    output mac_addr_t tx_tha,
    output ip_addr_t  tx_tpa,
    // host lookups
    input  logic      req_valid,
    output logic      req_ready,
    input  ip_addr_t  req_ip,
    output logic      resp_valid,
    input  logic      resp_ready,
    output logic      resp_error,
    output mac_addr_t resp_mac,
    // configuration
    input  mac_addr_t local_mac,
    input  ip_addr_t  local_ip,
    input  ip_addr_t  gateway_ip,
    input  ip_addr_t  subnet_mask,
    input  logic      clear_cache
);

    arp_tx_req_if reply_if ();
    arp_tx_req_if request_if ();
    arp_cache_if  cache_if ();

    arp_frame_decode u_frame_decode (
        .clk        (clk),
        .rst        (rst),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_src_mac (rx_src_mac),
        .rx_oper    (rx_oper),
        .rx_sha     (rx_sha),
        .rx_spa     (rx_spa),
        .rx_tha     (rx_tha),
        .rx_tpa     (rx_tpa),
        .local_mac  (local_mac),
        .local_ip   (local_ip),
        .reply      (reply_if.source),
        .cache      (cache_if.writer)
    );

    arp_cache u_cache (
        .clk         (clk),
        .rst         (rst),
        .clear_cache (clear_cache),
        .port        (cache_if.responder)
    );

    arp_resolver u_resolver (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_ip      (req_ip),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_error  (resp_error),
        .resp_mac    (resp_mac),
        .gateway_ip  (gateway_ip),
        .subnet_mask (subnet_mask),
        .cache       (cache_if.requester),
        .request     (request_if.source)
    );

    arp_tx_frame u_tx_frame (
        .clk         (clk),
        .rst         (rst),
        .reply       (reply_if.sink),
        .request     (request_if.sink),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_dest_mac (tx_dest_mac),
        .tx_oper     (tx_oper),
        .tx_tha      (tx_tha),
        .tx_tpa      (tx_tpa)
    );

endmodule

// File: logic/arp_tx_frame.sv
`timescale 1ns/1ps

module arp_tx_frame import arp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    arp_tx_req_if.sink reply,
    arp_tx_req_if.sink request,
    output logic       tx_valid,
    input  logic       tx_ready,
    output mac_addr_t  tx_dest_mac,
    output arp_oper_t  tx_oper,
    output mac_addr_t  tx_tha,
    output ip_addr_t   tx_tpa
);

    logic slot_free;

    // empty, or the current frame leaves this cycle
    assign slot_free = !tx_valid || tx_ready;

    // resolver has priority over the reply path
    assign request.ready = slot_free;
    assign reply.ready   = slot_free && !request.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (request.valid || reply.valid) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (request.valid) begin
            tx_dest_mac <= request.dest_mac;
            tx_oper     <= request.oper;
            tx_tha      <= request.tha;
            tx_tpa      <= request.tpa;
        end else if (reply.valid) begin
            tx_dest_mac <= reply.dest_mac;
            tx_oper     <= reply.oper;
            tx_tha      <= reply.tha;
            tx_tpa      <= reply.tpa;
        end
    end

endmodule

// File: verif/arp_assertions.sv
`timescale 1ns/1ps

module arp_assertions import arp_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      rx_valid,
    input logic      rx_ready,
    input mac_addr_t rx_src_mac,
    input arp_oper_t rx_oper,
    input mac_addr_t rx_sha,
    input ip_addr_t  rx_spa,
    input mac_addr_t rx_tha,
    input ip_addr_t  rx_tpa,
    input logic      tx_valid,
    input logic      tx_ready,
    input mac_addr_t tx_dest_mac,
    input arp_oper_t tx_oper,
    input mac_addr_t tx_tha,
    input ip_addr_t  tx_tpa,
    input logic      req_valid,
    input logic      req_ready,
    input ip_addr_t  req_ip,
    input logic      resp_valid,
    input logic      resp_ready,
    input logic      resp_error,
    input mac_addr_t resp_mac,
    input mac_addr_t local_mac,
    input ip_addr_t  local_ip,
    input ip_addr_t  gateway_ip,
    input ip_addr_t  subnet_mask
);

    int        error_count = 0;
    logic      reply_due;
    arp_oper_t reply_oper;
    logic      bcast_req;

    // requests aimed at this station by ip or by mac
    assign reply_due = rx_valid && rx_ready &&
                       (((rx_oper == ARP_OPER_REQUEST) && (rx_tpa == local_ip)) ||
                        ((rx_oper == ARP_OPER_INARP_REQUEST) && (rx_tha == local_mac)));
    assign reply_oper = (rx_oper == ARP_OPER_INARP_REQUEST) ? ARP_OPER_INARP_REPLY
                                                            : ARP_OPER_REPLY;
    // limited broadcast or all host bits set in the gateway subnet
    assign bcast_req = (req_ip == IP_BROADCAST) ||
                       (((req_ip & subnet_mask) == (gateway_ip & subnet_mask)) &&
                        ((req_ip | subnet_mask) == IP_BROADCAST));

    reset_idle: assert property (@(posedge clk) rst |=> !tx_valid && !resp_valid && !req_ready)
        else begin
            error_count = error_count + 1;
            $error("outputs not idle after reset");
        end

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_dest_mac) && $stable(tx_oper) &&
                                  $stable(tx_tha) && $stable(tx_tpa))
        else begin
            error_count = error_count + 1;
            $error("tx frame changed while stalled");
        end

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_error) && $stable(resp_mac))
        else begin
            error_count = error_count + 1;
            $error("lookup response changed while stalled");
        end

    // reply goes back to the sender with its own binding as target
    reply_fields: assert property (@(posedge clk) disable iff (rst)
        reply_due |=> tx_valid && (tx_oper == $past(reply_oper)) &&
                      (tx_dest_mac == $past(rx_src_mac)) && (tx_tha == $past(rx_sha)) &&
                      (tx_tpa == $past(rx_spa)))
        else begin
            error_count = error_count + 1;
            $error("reply frame fields wrong");
        end

    request_fields: assert property (@(posedge clk) disable iff (rst)
        tx_valid && (tx_oper == ARP_OPER_REQUEST) |-> (tx_dest_mac == MAC_BROADCAST) &&
                                                      (tx_tha == '0))
        else begin
            error_count = error_count + 1;
            $error("request frame not broadcast");
        end

    bcast_answer: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && bcast_req |=> resp_valid && !resp_error &&
                                                (resp_mac == MAC_BROADCAST))
        else begin
            error_count = error_count + 1;
            $error("broadcast lookup not answered with the broadcast mac");
        end

endmodule

// File: verif/arp_tb.sv
`timescale 1ns/1ps

module arp_tb import arp_pkg::*; ();

    typedef struct packed {
        mac_addr_t dest_mac;
        arp_oper_t oper;
        mac_addr_t tha;
        ip_addr_t  tpa;
    } tx_frame_t;

    logic      clk;
    logic      rst;
    logic      rx_valid;
    logic      rx_ready;
    mac_addr_t rx_src_mac;
    arp_oper_t rx_oper;
    mac_addr_t rx_sha;
    ip_addr_t  rx_spa;
    mac_addr_t rx_tha;
    ip_addr_t  rx_tpa;
    logic      tx_valid;
    logic      tx_ready;
    mac_addr_t tx_dest_mac;
    arp_oper_t tx_oper;
    mac_addr_t tx_tha;
    ip_addr_t  tx_tpa;
    logic      req_valid;
    logic      req_ready;
    ip_addr_t  req_ip;
    logic      resp_valid;
    logic      resp_ready;
    logic      resp_error;
    mac_addr_t resp_mac;
    mac_addr_t local_mac;
    ip_addr_t  local_ip;
    ip_addr_t  gateway_ip;
    ip_addr_t  subnet_mask;
    logic      clear_cache;

    logic [31:0] lfsr_state;
    mac_addr_t   learned [ip_addr_t];
    tx_frame_t   sent [$];
    ip_addr_t    host_ip [2];
    mac_addr_t   host_mac [2];

    arp_top u_arp_top (.*);

    bind arp_top arp_assertions u_arp_assertions (.*);

    always #5 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("Error at %0d ns: %s", $time, msg));
    endtask

    // random back-pressure on both output channels
    always @(posedge clk) begin
        if (rst) begin
            tx_ready   <= 1'b1;
            resp_ready <= 1'b1;
        end else begin
            tx_ready   <= 1'(take_bits(1) | take_bits(1));
            resp_ready <= 1'(take_bits(1));
        end
    end

    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            sent.push_back('{tx_dest_mac, tx_oper, tx_tha, tx_tpa});
        end
    end

    always @(posedge clk) begin
        if (u_arp_top.u_arp_assertions.error_count != 0) begin
            abort_run("bound assertion checker reported a protocol violation");
        end
    end

    // nine lookups at most a full miss each plus margin for frames and stalls
    initial begin
        int limit;
        limit = 9 * (REQUEST_RETRY_COUNT * RETRY_INTERVAL_CYCLES + REQUEST_TIMEOUT_CYCLES) + 2000;
        repeat (limit) @(posedge clk);
        abort_run("run timed out waiting for a DUT handshake");
    end

    task automatic send_frame(input mac_addr_t sha, input arp_oper_t oper, input ip_addr_t spa,
                              input mac_addr_t tha, input ip_addr_t tpa);
        @(posedge clk);
        rx_valid   <= 1'b1;
        rx_src_mac <= sha;
        rx_oper    <= oper;
        rx_sha     <= sha;
        rx_spa     <= spa;
        rx_tha     <= tha;
        rx_tpa     <= tpa;
        do @(posedge clk); while (!rx_ready);
        rx_valid <= 1'b0;
        learned[spa] = sha;
    endtask

    task automatic drain_tx();
        repeat (2) @(posedge clk);
        while (tx_valid) @(posedge clk);
    endtask

    task automatic check_lookup(input ip_addr_t ip);
        ip_addr_t  target;
        logic      err;
        mac_addr_t mac;
        logic      known;
        mac_addr_t want;
        @(posedge clk);
        req_valid <= 1'b1;
        req_ip    <= ip;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        do @(posedge clk); while (!(resp_valid && resp_ready));
        err = resp_error;
        mac = resp_mac;
        // table as it stands when the answer arrives
        target = ((ip & subnet_mask) == (gateway_ip & subnet_mask)) ? ip : gateway_ip;
        if ((ip == IP_BROADCAST) || ((target == ip) && ((ip | subnet_mask) == IP_BROADCAST))) begin
            known = 1'b1;
            want  = MAC_BROADCAST;
        end else begin
            known = learned.exists(target);
            want  = known ? learned[target] : '0;
        end
        assert (err == !known)
            else value_error($sformatf("lookup %h error %0b, expected %0b", ip, err, !known));
        assert (!known || (mac == want))
            else value_error($sformatf("lookup %h mac %h, expected %h", ip, mac, want));
    endtask

    task automatic check_reply(input int base, input arp_oper_t oper, input mac_addr_t mac,
                               input ip_addr_t ip);
        drain_tx();
        assert (sent.size() == base + 1)
            else value_error($sformatf("%0d frames for one request to us", sent.size() - base));
        assert ((sent[base].oper == oper) && (sent[base].dest_mac == mac) &&
                (sent[base].tha == mac) && (sent[base].tpa == ip))
            else value_error($sformatf("reply to %h has wrong fields", ip));
    endtask

    task automatic check_requests(input int base, input ip_addr_t ip);
        drain_tx();
        assert (sent.size() - base == REQUEST_RETRY_COUNT)
            else value_error($sformatf("%0d request frames for %h", sent.size() - base, ip));
        for (int i = base; i < sent.size(); i++) begin
            assert ((sent[i].dest_mac == MAC_BROADCAST) && (sent[i].oper == ARP_OPER_REQUEST) &&
                    (sent[i].tpa == ip))
                else value_error($sformatf("request frame %0d for %h is wrong", i - base, ip));
        end
    endtask

    initial begin
        logic [31:0] r;
        ip_addr_t    far_ip;
        mac_addr_t   gw_mac;
        int          base;
        lfsr_state  = 32'hee280765;
        clk         = 1'b0;
        rst         = 1'b1;
        rx_valid    = 1'b0;
        rx_src_mac  = '0;
        rx_oper     = ARP_OPER_REQUEST;
        rx_sha      = '0;
        rx_spa      = '0;
        rx_tha      = '0;
        rx_tpa      = '0;
        tx_ready    = 1'b1;
        req_valid   = 1'b0;
        req_ip      = '0;
        resp_ready  = 1'b1;
        local_mac   = 48'h0200_5e10_0001;
        local_ip    = 32'hc0a8010a;
        gateway_ip  = 32'hc0a80101;
        subnet_mask = 32'hffffff00;
        clear_cache = 1'b0;
        // hosts land in .32 to .63 away from the fixed addresses
        for (int i = 0; i < 2; i++) begin
            r           = take_bits(4);
            host_ip[i]  = {24'hc0a801, 4'(i + 2), r[3:0]};
            host_mac[i] = {16'h0200, take_bits(32)};
        end
        r      = take_bits(24);
        far_ip = {8'd10, r[23:0]};
        gw_mac = {16'h0200, take_bits(32)};
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        base = sent.size();
        check_lookup(IP_BROADCAST);
        check_lookup(32'hc0a801ff);
        drain_tx();
        assert (sent.size() == base) else value_error("broadcast lookup sent a frame");

        base = sent.size();
        send_frame(48'h0200_0000_0011, ARP_OPER_REQUEST, 32'hc0a80111, '0, local_ip);
        check_reply(base, ARP_OPER_REPLY, 48'h0200_0000_0011, 32'hc0a80111);
        base = sent.size();
        send_frame(48'h0200_0000_0012, ARP_OPER_INARP_REQUEST, 32'hc0a80112, local_mac, '0);
        check_reply(base, ARP_OPER_INARP_REPLY, 48'h0200_0000_0012, 32'hc0a80112);
        // aimed at some other station
        base = sent.size();
        send_frame(48'h0200_0000_0013, ARP_OPER_REQUEST, 32'hc0a80113, '0, 32'hc0a80163);
        send_frame(48'h0200_0000_0014, ARP_OPER_INARP_REQUEST, 32'hc0a80114,
                   48'h0200_0000_0063, '0);
        drain_tx();
        assert (sent.size() == base) else value_error("reply sent for a frame aimed elsewhere");

        for (int i = 0; i < 2; i++) begin
            send_frame(host_mac[i], ARP_OPER_REPLY, host_ip[i], local_mac, local_ip);
            check_lookup(host_ip[i]);
        end
        check_lookup(32'hc0a80111);
        send_frame(gw_mac, ARP_OPER_REPLY, gateway_ip, local_mac, local_ip);
        check_lookup(far_ip);

        // unknown host gets the full retry sequence then an error
        base = sent.size();
        check_lookup(32'hc0a801c8);
        check_requests(base, 32'hc0a801c8);

        // answer arrives after the first request frame
        fork
            check_lookup(32'hc0a801c9);
            begin
                do @(posedge clk); while (!(tx_valid && tx_ready && (tx_tpa == 32'hc0a801c9)));
                send_frame(48'h0200_0000_00c9, ARP_OPER_REPLY, 32'hc0a801c9, local_mac, local_ip);
            end
        join

        @(posedge clk);
        clear_cache <= 1'b1;
        @(posedge clk);
        clear_cache <= 1'b0;
        learned.delete();
        drain_tx();
        base = sent.size();
        check_lookup(host_ip[0]);
        check_requests(base, host_ip[0]);

        if (u_arp_top.u_arp_assertions.error_count != 0) begin
            abort_run("bound assertion checker reported a protocol violation");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
